/* logic/radio_regs_pkg.sv */
package radio_regs_pkg;

   typedef logic [7:0]  set_addr_t;   // settings and readback address
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] rb_data_t;    // readback word, two 32-bit halves

   // --------------------------------------------------
   // settings bus map, daughterboard block
   // --------------------------------------------------
   localparam set_addr_t SR_DB_BASE     = 8'd160;
   localparam set_addr_t SR_MISC_OUT    = SR_DB_BASE + 8'd0;
   localparam set_addr_t SR_LEDS        = SR_DB_BASE + 8'd1;
   localparam set_addr_t SR_DB_GPIO_OUT = SR_DB_BASE + 8'd2;
   localparam set_addr_t SR_DB_GPIO_DDR = SR_DB_BASE + 8'd3;

   // --------------------------------------------------
   // settings bus map, front end block
   // --------------------------------------------------
   localparam set_addr_t SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;   // 208
   localparam set_addr_t SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;   // 224
   localparam set_addr_t SR_FE_CHAN_OFFSET = 8'd16;   // stride between channels

   // --------------------------------------------------
   // readback map
   // --------------------------------------------------
   localparam set_addr_t RB_DB_BASE    = 8'd16;
   localparam set_addr_t RB_MISC       = RB_DB_BASE + 8'd0;
   localparam set_addr_t RB_GPIO       = RB_DB_BASE + 8'd1;
   localparam set_addr_t RB_LEDS       = RB_DB_BASE + 8'd2;
   localparam set_addr_t RB_RX_OFFSETS = RB_DB_BASE + 8'd3;

   // radio LEDs, order is {rx, txrx_tx, txrx_rx}
   localparam int LED_WIDTH = 3;

endpackage

/* logic/radio_sample_pkg.sv */
package radio_sample_pkg;

   // two channels share the one daughterboard
   localparam int NUM_CHANNELS = 2;
   localparam int IQ_WIDTH     = 16;

   // one I or Q component
   typedef logic [IQ_WIDTH-1:0] iq_t;

   // one complex sample, also the layout of the rx offset register
   typedef struct packed {
      iq_t i;   // upper half
      iq_t q;   // lower half
   } sample_t;

   typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_idx_t;

endpackage

/* logic/setting_decode.sv */
module setting_decode
   import radio_regs_pkg::*;
   import radio_sample_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_rst_n,
   // settings bus
   input  logic                 i_set_stb,
   input  set_addr_t            i_set_addr,
   input  set_data_t            i_set_data,
   // daughterboard registers
   output set_data_t            o_misc_out,
   output logic [LED_WIDTH-1:0] o_radio_led,
   output set_data_t            o_db_gpio_out,
   output set_data_t            o_db_gpio_ddr,
   // front end registers
   output sample_t              o_rx_offset [NUM_CHANNELS],
   output logic                 o_tx_swap   [NUM_CHANNELS]
);

   logic      set_stb_r;
   set_addr_t set_addr_r;
   set_data_t set_data_r;

   set_addr_t rx_rel;
   set_addr_t tx_rel;
   logic      rx_hit;
   logic      tx_hit;
   chan_idx_t rx_chan;
   chan_idx_t tx_chan;

   // true when rel lands on a channel base inside the front end block
   function automatic logic fe_hit(input set_addr_t rel);
      logic on_stride;
      logic in_range;
      on_stride = (rel % SR_FE_CHAN_OFFSET) == 8'd0;
      in_range  = int'(rel) < NUM_CHANNELS * int'(SR_FE_CHAN_OFFSET);
      return on_stride && in_range;
   endfunction

   // --------------------------------------------------
   // capture stage
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         set_stb_r <= 1'b0;
      end else begin
         set_stb_r <= i_set_stb;
      end
      set_addr_r <= i_set_addr;   // qualified by set_stb_r
      set_data_r <= i_set_data;
   end

   // front end decode, addresses below a base wrap high and miss the range
   always_comb begin
      rx_rel  = set_addr_r - SR_RX_FE_BASE;
      tx_rel  = set_addr_r - SR_TX_FE_BASE;
      rx_hit  = fe_hit(rx_rel);
      tx_hit  = fe_hit(tx_rel);
      rx_chan = chan_idx_t'(rx_rel / SR_FE_CHAN_OFFSET);
      tx_chan = chan_idx_t'(tx_rel / SR_FE_CHAN_OFFSET);
   end

   // --------------------------------------------------
   // register update stage
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_misc_out    <= '0;
         o_radio_led   <= '0;
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            o_rx_offset[c] <= '0;
            o_tx_swap[c]   <= 1'b0;
         end
      end else if (set_stb_r) begin
         case (set_addr_r)
            SR_MISC_OUT:    o_misc_out    <= set_data_r;
            SR_LEDS:        o_radio_led   <= set_data_r[LED_WIDTH-1:0];
            SR_DB_GPIO_OUT: o_db_gpio_out <= set_data_r;
            SR_DB_GPIO_DDR: o_db_gpio_ddr <= set_data_r;
            default: ;   // not a daughterboard register
         endcase

         // tx channel 1 shares its address with rx channel 0, both take the write
         if (rx_hit) begin
            o_rx_offset[rx_chan] <= sample_t'(set_data_r);
         end
         if (tx_hit) begin
            o_tx_swap[tx_chan] <= set_data_r[0];   // only bit 0 is kept
         end
      end
   end

endmodule

/* logic/fe_datapath.sv */
module fe_datapath
   import radio_sample_pkg::*;
(
   input  logic    radio_clk,
   input  logic    i_rst_n,
   // per channel settings from the decode stage
   input  sample_t i_rx_offset [NUM_CHANNELS],
   input  logic    i_tx_swap   [NUM_CHANNELS],
   // receive path
   input  logic    i_rx_stb    [NUM_CHANNELS],
   input  sample_t i_rx_data   [NUM_CHANNELS],
   output logic    o_rx_stb    [NUM_CHANNELS],
   output sample_t o_rx_data   [NUM_CHANNELS],
   // transmit path
   input  logic    i_tx_stb    [NUM_CHANNELS],
   input  sample_t i_tx_data   [NUM_CHANNELS],
   output logic    o_tx_stb    [NUM_CHANNELS],
   output sample_t o_tx_data   [NUM_CHANNELS]
);

   sample_t rx_corr [NUM_CHANNELS];
   sample_t tx_next [NUM_CHANNELS];

   // --------------------------------------------------
   // per channel sample math
   // --------------------------------------------------
   always_comb begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         // dc offset removal, each half wraps on its own
         rx_corr[c].i = i_rx_data[c].i - i_rx_offset[c].i;
         rx_corr[c].q = i_rx_data[c].q - i_rx_offset[c].q;

         if (i_tx_swap[c]) begin
            tx_next[c] = sample_t'({i_tx_data[c].q, i_tx_data[c].i});   // iq swap
         end else begin
            tx_next[c] = i_tx_data[c];
         end
      end
   end

   // receive output registers
   always_ff @(posedge radio_clk) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (!i_rst_n) begin
            o_rx_stb[c]  <= 1'b0;
            o_rx_data[c] <= '0;
         end else begin
            o_rx_stb[c] <= i_rx_stb[c];
            if (i_rx_stb[c]) begin
               o_rx_data[c] <= rx_corr[c];   // holds between strobes
            end
         end
      end
   end

   // transmit output registers
   always_ff @(posedge radio_clk) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (!i_rst_n) begin
            o_tx_stb[c]  <= 1'b0;
            o_tx_data[c] <= '0;
         end else begin
            o_tx_stb[c] <= i_tx_stb[c];
            if (i_tx_stb[c]) begin
               o_tx_data[c] <= tx_next[c];
            end
         end
      end
   end

endmodule

/* logic/readback_mux.sv */
module readback_mux
   import radio_regs_pkg::*;
   import radio_sample_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_rst_n,
   // readback request
   input  logic                 i_rb_stb,
   input  set_addr_t            i_rb_addr,
   // sources
   input  set_data_t            i_misc_in,
   input  set_data_t            i_misc_out,
   input  set_data_t            i_db_gpio_in,
   input  set_data_t            i_db_gpio_ddr,
   input  logic [LED_WIDTH-1:0] i_radio_led,
   input  sample_t              i_rx_offset [NUM_CHANNELS],
   // response
   output logic                 o_rb_valid,
   output rb_data_t             o_rb_data
);

   set_data_t misc_in_sync;
   logic      rb_stb_r;
   set_addr_t rb_addr_r;
   rb_data_t  rb_word;

   // misc inputs come from the board, one register into radio_clk
   always_ff @(posedge radio_clk) begin
      misc_in_sync <= i_misc_in;
   end

   // request capture
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rb_stb_r <= 1'b0;
      end else begin
         rb_stb_r <= i_rb_stb;
      end
      rb_addr_r <= i_rb_addr;
   end

   // --------------------------------------------------
   // word select, upper half listed first
   // --------------------------------------------------
   always_comb begin
      case (rb_addr_r)
         RB_MISC:       rb_word = {i_misc_out, misc_in_sync};
         RB_GPIO:       rb_word = {i_db_gpio_ddr, i_db_gpio_in};
         RB_LEDS:       rb_word = rb_data_t'(i_radio_led);   // zero extended
         RB_RX_OFFSETS: rb_word = {i_rx_offset[1], i_rx_offset[0]};
         default:       rb_word = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_valid <= 1'b0;
         o_rb_data  <= '0;
      end else begin
         o_rb_valid <= rb_stb_r;   // one cycle pulse per request
         if (rb_stb_r) begin
            o_rb_data <= rb_word;
         end
      end
   end

endmodule

/* logic/x300_radio_ctrl.sv */
module x300_radio_ctrl
   import radio_regs_pkg::*;
   import radio_sample_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_rst_n,
   // settings bus
   input  logic                 i_set_stb,
   input  set_addr_t            i_set_addr,
   input  set_data_t            i_set_data,
   // readback bus
   input  logic                 i_rb_stb,
   input  set_addr_t            i_rb_addr,
   output logic                 o_rb_valid,
   output rb_data_t             o_rb_data,
   // sample streams
   input  logic                 i_rx_stb  [NUM_CHANNELS],
   input  sample_t              i_rx_data [NUM_CHANNELS],
   output logic                 o_rx_stb  [NUM_CHANNELS],
   output sample_t              o_rx_data [NUM_CHANNELS],
   input  logic                 i_tx_stb  [NUM_CHANNELS],
   input  sample_t              i_tx_data [NUM_CHANNELS],
   output logic                 o_tx_stb  [NUM_CHANNELS],
   output sample_t              o_tx_data [NUM_CHANNELS],
   // daughterboard pins
   input  set_data_t            i_misc_in,
   output set_data_t            o_misc_out,
   input  set_data_t            i_db_gpio_in,
   output set_data_t            o_db_gpio_out,
   output set_data_t            o_db_gpio_ddr,
   output logic [LED_WIDTH-1:0] o_radio_led
);

   sample_t rx_offset [NUM_CHANNELS];
   logic    tx_swap   [NUM_CHANNELS];

   // --------------------------------------------------
   // decode, execute, result
   // --------------------------------------------------
   setting_decode setting_decode_inst (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .o_misc_out    (o_misc_out),
      .o_radio_led   (o_radio_led),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_rx_offset   (rx_offset),
      .o_tx_swap     (tx_swap)
   );

   fe_datapath fe_datapath_inst (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_rx_offset (rx_offset),
      .i_tx_swap   (tx_swap),
      .i_rx_stb    (i_rx_stb),
      .i_rx_data   (i_rx_data),
      .o_rx_stb    (o_rx_stb),
      .o_rx_data   (o_rx_data),
      .i_tx_stb    (i_tx_stb),
      .i_tx_data   (i_tx_data),
      .o_tx_stb    (o_tx_stb),
      .o_tx_data   (o_tx_data)
   );

   // readback sees the register values as they leave the decode stage
   readback_mux readback_mux_inst (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_rb_stb      (i_rb_stb),
      .i_rb_addr     (i_rb_addr),
      .i_misc_in     (i_misc_in),
      .i_misc_out    (o_misc_out),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_db_gpio_ddr (o_db_gpio_ddr),
      .i_radio_led   (o_radio_led),
      .i_rx_offset   (rx_offset),
      .o_rb_valid    (o_rb_valid),
      .o_rb_data     (o_rb_data)
   );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
   parameter int PERIOD = 4
) (
   output logic o_clk
);

   // free running, starts low
   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD / 2) o_clk = ~o_clk;
      end
   end

endmodule

/* tests/x300_radio_ctrl_tb.sv */
module x300_radio_ctrl_tb
   import radio_regs_pkg::*;
   import radio_sample_pkg::*;
();

   // cycle budget per test sets the run limit
   localparam int T1_CYCLES      = 10;
   localparam int T2_CYCLES      = 40;
   localparam int T3_CYCLES      = 45;
   localparam int T4_CYCLES      = 55;
   localparam int T5_CYCLES      = 55;
   localparam int TIMEOUT_CYCLES =
      2 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES) + 100;
   localparam int RB_WAIT_LIMIT  = 8;

   localparam set_addr_t DB_ADDRS [4] =
      '{SR_MISC_OUT, SR_LEDS, SR_DB_GPIO_OUT, SR_DB_GPIO_DDR};
   localparam set_addr_t BAD_ADDRS [6] =
      '{8'd0, 8'd100, 8'd164, 8'd200, 8'd209, 8'd250};
   // offsets last so later offset writes show whether the word holds
   localparam set_addr_t RB_ADDRS [5] =
      '{RB_MISC, RB_GPIO, RB_LEDS, 8'd23, RB_RX_OFFSETS};

   logic                 radio_clk;
   logic                 i_rst_n;
   logic                 i_set_stb;
   set_addr_t            i_set_addr;
   set_data_t            i_set_data;
   logic                 i_rb_stb;
   set_addr_t            i_rb_addr;
   logic                 o_rb_valid;
   rb_data_t             o_rb_data;
   logic                 i_rx_stb  [NUM_CHANNELS];
   sample_t              i_rx_data [NUM_CHANNELS];
   logic                 o_rx_stb  [NUM_CHANNELS];
   sample_t              o_rx_data [NUM_CHANNELS];
   logic                 i_tx_stb  [NUM_CHANNELS];
   sample_t              i_tx_data [NUM_CHANNELS];
   logic                 o_tx_stb  [NUM_CHANNELS];
   sample_t              o_tx_data [NUM_CHANNELS];
   set_data_t            i_misc_in;
   set_data_t            o_misc_out;
   set_data_t            i_db_gpio_in;
   set_data_t            o_db_gpio_out;
   set_data_t            o_db_gpio_ddr;
   logic [LED_WIDTH-1:0] o_radio_led;

   // reference model state
   set_data_t            exp_misc_out;
   logic [LED_WIDTH-1:0] exp_led;
   set_data_t            exp_gpio_out;
   set_data_t            exp_gpio_ddr;
   sample_t              exp_rx_off  [NUM_CHANNELS];
   logic                 exp_tx_swap [NUM_CHANNELS];
   sample_t              exp_rx_data [NUM_CHANNELS];
   sample_t              exp_tx_data [NUM_CHANNELS];
   rb_data_t             exp_rb_data;
   logic                 wr_stb_q;
   set_addr_t            wr_addr_q;
   set_data_t            wr_data_q;
   logic                 rb_stb_q;
   set_addr_t            rb_addr_q;
   set_data_t            misc_in_q;
   logic                 outputs_zero;

   logic [31:0] lfsr_state;
   int          error_count  = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          test_index   = 0;
   int          start_errors = 0;
   int          cycle_count  = 0;
   int          valid_count  = 0;
   int          rb_issued    = 0;

   tb_clock_gen #(.PERIOD(4)) tb_clock_gen_inst (.o_clk(radio_clk));

   x300_radio_ctrl x300_radio_ctrl_inst (.*);

   task automatic value_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
      $display("CHECK FAILED %s expected %h got %h", name, exp_v, got_v);
      error_count++;
   endtask

   task automatic protocol_miss(input string what);
      $display("error: %s", what);
      error_count++;
   endtask

   // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic sample_t offset_removed(input sample_t s, input sample_t off);
      logic [IQ_WIDTH-1:0] i_part;
      logic [IQ_WIDTH-1:0] q_part;
      i_part = s[2*IQ_WIDTH-1:IQ_WIDTH] - off[2*IQ_WIDTH-1:IQ_WIDTH];   // mod 2^16
      q_part = s[IQ_WIDTH-1:0] - off[IQ_WIDTH-1:0];
      return sample_t'({i_part, q_part});
   endfunction

   function automatic rb_data_t expected_word(input set_addr_t addr);
      case (addr)
         RB_MISC:       return {exp_misc_out, misc_in_q};
         RB_GPIO:       return {exp_gpio_ddr, i_db_gpio_in};
         RB_LEDS:       return {32'd0, 32'(exp_led)};
         RB_RX_OFFSETS: return {exp_rx_off[1], exp_rx_off[0]};
         default:       return '0;
      endcase
   endfunction

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   always @(posedge radio_clk) begin
      if (!i_rst_n) begin
         wr_stb_q     <= 1'b0;
         exp_misc_out <= '0;
         exp_led      <= '0;
         exp_gpio_out <= '0;
         exp_gpio_ddr <= '0;
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            exp_rx_off[c]  <= '0;
            exp_tx_swap[c] <= 1'b0;
         end
      end else begin
         wr_stb_q  <= i_set_stb;   // write lands one edge after capture
         wr_addr_q <= i_set_addr;
         wr_data_q <= i_set_data;
         if (wr_stb_q) begin
            if (wr_addr_q == SR_MISC_OUT) exp_misc_out <= wr_data_q;
            if (wr_addr_q == SR_LEDS) exp_led <= wr_data_q[LED_WIDTH-1:0];
            if (wr_addr_q == SR_DB_GPIO_OUT) exp_gpio_out <= wr_data_q;
            if (wr_addr_q == SR_DB_GPIO_DDR) exp_gpio_ddr <= wr_data_q;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
               if (int'(wr_addr_q) == int'(SR_RX_FE_BASE) + c * int'(SR_FE_CHAN_OFFSET))
                  exp_rx_off[c] <= sample_t'(wr_data_q);
               if (int'(wr_addr_q) == int'(SR_TX_FE_BASE) + c * int'(SR_FE_CHAN_OFFSET))
                  exp_tx_swap[c] <= wr_data_q[0];
            end
         end
      end
   end

   always @(posedge radio_clk) begin
      misc_in_q <= i_misc_in;
      if (!i_rst_n) begin
         rb_stb_q    <= 1'b0;
         exp_rb_data <= '0;
      end else begin
         rb_stb_q  <= i_rb_stb;
         rb_addr_q <= i_rb_addr;
         if (rb_stb_q) exp_rb_data <= expected_word(rb_addr_q);
      end
      if (o_rb_valid) valid_count <= valid_count + 1;
   end

   always @(posedge radio_clk) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (!i_rst_n) begin
            exp_rx_data[c] <= '0;
            exp_tx_data[c] <= '0;
         end else begin
            if (i_rx_stb[c]) exp_rx_data[c] <= offset_removed(i_rx_data[c], exp_rx_off[c]);
            if (i_tx_stb[c]) begin
               exp_tx_data[c] <= exp_tx_swap[c]
                  ? sample_t'({i_tx_data[c][IQ_WIDTH-1:0], i_tx_data[c][2*IQ_WIDTH-1:IQ_WIDTH]})
                  : i_tx_data[c];
            end
         end
      end
   end

   always_comb begin
      outputs_zero = !o_rb_valid && o_rb_data == '0 && o_misc_out == '0
                     && o_db_gpio_out == '0 && o_db_gpio_ddr == '0 && o_radio_led == '0;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (o_rx_stb[c] || o_tx_stb[c] || o_rx_data[c] != '0 || o_tx_data[c] != '0)
            outputs_zero = 1'b0;
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   reset_clear: assert property (@(posedge radio_clk) $rose(i_rst_n) |-> outputs_zero)
      else protocol_miss("outputs are not all zero after reset");

   misc_out_val: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_misc_out == exp_misc_out)
      else value_mismatch("o_misc_out", 64'($sampled(exp_misc_out)),
                          64'($sampled(o_misc_out)));
   led_val: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_radio_led == exp_led)
      else value_mismatch("o_radio_led", 64'($sampled(exp_led)), 64'($sampled(o_radio_led)));
   gpio_out_val: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_db_gpio_out == exp_gpio_out)
      else value_mismatch("o_db_gpio_out", 64'($sampled(exp_gpio_out)),
                          64'($sampled(o_db_gpio_out)));
   gpio_ddr_val: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_db_gpio_ddr == exp_gpio_ddr)
      else value_mismatch("o_db_gpio_ddr", 64'($sampled(exp_gpio_ddr)),
                          64'($sampled(o_db_gpio_ddr)));

   // readback answers two edges after the strobe is sampled
   rb_pulse: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      $past(i_rb_stb, 2) |-> o_rb_valid)
      else protocol_miss("readback strobe got no valid pulse");
   rb_extra: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      !$past(i_rb_stb, 2) |-> !o_rb_valid)
      else protocol_miss("readback valid pulse without a strobe");
   rb_word: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb_data == exp_rb_data)
      else value_mismatch("o_rb_data", $sampled(exp_rb_data), $sampled(o_rb_data));

   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         $past(i_rx_stb[c]) |-> o_rx_stb[c])
         else protocol_miss($sformatf("rx sample on channel %0d got no output strobe", c));
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         !$past(i_rx_stb[c]) |-> !o_rx_stb[c])
         else protocol_miss($sformatf("rx output strobe on channel %0d with no input", c));
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         o_rx_data[c] == exp_rx_data[c])
         else value_mismatch($sformatf("o_rx_data[%0d]", c), 64'($sampled(exp_rx_data[c])),
                             64'($sampled(o_rx_data[c])));
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         $past(i_tx_stb[c]) |-> o_tx_stb[c])
         else protocol_miss($sformatf("tx sample on channel %0d got no output strobe", c));
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         !$past(i_tx_stb[c]) |-> !o_tx_stb[c])
         else protocol_miss($sformatf("tx output strobe on channel %0d with no input", c));
      assert property (@(posedge radio_clk) disable iff (!i_rst_n)
         o_tx_data[c] == exp_tx_data[c])
         else value_mismatch($sformatf("o_tx_data[%0d]", c), 64'($sampled(exp_tx_data[c])),
                             64'($sampled(o_tx_data[c])));
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic next_cycle();
      @(posedge radio_clk);
      #1;   // inputs change just after the edge
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic write_reg(input set_addr_t addr, input set_data_t data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      next_cycle();
      i_set_stb  = 1'b0;
   endtask

   task automatic wait_readbacks();
      int waited;
      waited = 0;
      while (valid_count < rb_issued && waited < RB_WAIT_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (valid_count < rb_issued) protocol_miss("readback valid did not arrive in time");
   endtask

   // reads n entries of the readback address table starting at first
   task automatic read_burst(input int first, input int n);
      for (int k = first; k < first + n; k++) begin
         i_rb_stb  = 1'b1;   // back to back when n > 1
         i_rb_addr = RB_ADDRS[k];
         next_cycle();
         rb_issued++;
      end
      i_rb_stb = 1'b0;
      wait_readbacks();
   endtask

   task automatic send_samples(input logic tx_side, input int n);
      for (int k = 0; k < n; k++) begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (tx_side) begin
               i_tx_stb[c]  = rand_bits(1) == 32'd1;   // random gaps
               i_tx_data[c] = sample_t'(rand_bits(32));
            end else begin
               i_rx_stb[c]  = rand_bits(1) == 32'd1;
               i_rx_data[c] = sample_t'(rand_bits(32));
            end
         end
         next_cycle();
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         i_tx_stb[c] = 1'b0;
         i_rx_stb[c] = 1'b0;
      end
   endtask

   task automatic open_test();
      test_index++;
      start_errors = error_count;
   endtask

   task automatic close_test(input string name);
      idle(3);   // drain the pipelines
      if (error_count == start_errors) begin
         tests_passed++;
         $display("test %0d %s passed", test_index, name);
      end else begin
         tests_failed++;
         $display("test %0d %s failed with %0d errors", test_index, name,
                  error_count - start_errors);
      end
   endtask

   always @(posedge radio_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int sel;

      lfsr_state   = 32'h86d4492a;
      i_rst_n      = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = 1'b0;
      i_rb_addr    = '0;
      i_misc_in    = '0;
      i_db_gpio_in = '0;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         i_rx_stb[c]  = 1'b0;
         i_rx_data[c] = '0;
         i_tx_stb[c]  = 1'b0;
         i_tx_data[c] = '0;
      end
      idle(3);
      i_rst_n = 1'b1;

      open_test();
      read_burst(2, 1);   // RB_LEDS straight out of reset
      close_test("reset state");

      open_test();
      for (int k = 0; k < 12; k++) begin
         sel = rand_bits(2);
         write_reg(DB_ADDRS[sel], rand_bits(32));
         if (rand_bits(1) == 32'd1) idle(1);
      end
      for (int k = 0; k < 6; k++) write_reg(BAD_ADDRS[k], rand_bits(32));
      close_test("daughterboard writes");

      open_test();
      write_reg(SR_RX_FE_BASE, rand_bits(32));
      write_reg(SR_RX_FE_BASE + SR_FE_CHAN_OFFSET, rand_bits(32));
      i_misc_in    = rand_bits(32);
      i_db_gpio_in = rand_bits(32);
      idle(3);   // misc and gpio inputs steady
      for (int k = 0; k < 5; k++) read_burst(k, 1);
      read_burst(0, 5);
      close_test("readback map");

      open_test();
      write_reg(SR_RX_FE_BASE, rand_bits(32));
      write_reg(SR_RX_FE_BASE + SR_FE_CHAN_OFFSET, rand_bits(32));
      idle(2);
      send_samples(1'b0, 40);
      close_test("rx offset removal");

      open_test();
      write_reg(SR_TX_FE_BASE, 32'd0);
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET, rand_bits(32) | 32'd1);
      idle(2);
      send_samples(1'b1, 20);
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET, rand_bits(32) & ~32'd1);
      idle(2);
      send_samples(1'b1, 20);
      close_test("tx iq swap");

      $display("tests %0d, passed %0d, failed %0d, check errors %0d",
               test_index, tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* x300_radio_ctrl.f */
logic/radio_regs_pkg.sv
logic/radio_sample_pkg.sv
logic/setting_decode.sv
logic/fe_datapath.sv
logic/readback_mux.sv
logic/x300_radio_ctrl.sv
tests/tb_clock_gen.sv
tests/x300_radio_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = x300_radio_ctrl_tb
FILELIST  = x300_radio_ctrl.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
